//--- hdl/dataframe_macros.svh
`ifndef DATAFRAME_MACROS_SVH
`define DATAFRAME_MACROS_SVH

// Word and beat widths
`define DATAFRAME_WIDTH     32
`define TDATA_WIDTH         64

// Frame layout, two header words per stream beat
`define HEADER_LINE         4
`define FOOTER_LINE         1
`define HEADER_BEATS        (`HEADER_LINE/2)

`define FRAME_LENGTH_WIDTH  12

// FIFO depths
`define DESC_FIFO_DEPTH     4
`define SAMPLE_FIFO_DEPTH   16

`endif

//--- hdl/frame_pkg.sv
`include "dataframe_macros.svh"

package frame_pkg;

    // ==============================
    // Descriptor fields
    // ==============================

    typedef logic [`FRAME_LENGTH_WIDTH-1:0] frame_len_t;
    typedef logic [`DATAFRAME_WIDTH-1:0] frame_word_t;

    // First header word, high to low
    typedef struct packed {
        logic [7:0] header_id;
        logic [7:0] ch_id;
        frame_len_t frame_len;
        logic [3:0] reserved;
    } header_word0_t;

    // Word 0 sits in the top bits
    typedef struct packed {
        header_word0_t word0;
        frame_word_t   word1;
        frame_word_t   word2;
        frame_word_t   word3;
    } frame_header_t;

    typedef struct packed {
        frame_header_t                               header;
        logic [`FOOTER_LINE-1:0][`DATAFRAME_WIDTH-1:0] footer;
    } frame_desc_t;

endpackage

//--- hdl/axis_pkg.sv
`include "dataframe_macros.svh"

package axis_pkg;

    // ==============================
    // Output stream
    // ==============================

    typedef logic [`TDATA_WIDTH-1:0] beat_t;
    typedef logic [`TDATA_WIDTH/8-1:0] keep_t;

    // All bytes valid
    localparam keep_t KEEP_FULL = {(`TDATA_WIDTH/8){1'b1}};

    // Low half only, used on the footer beat
    localparam keep_t KEEP_LOW_HALF = {{(`TDATA_WIDTH/16){1'b0}}, {(`TDATA_WIDTH/16){1'b1}}};

endpackage

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     ACLK,
    input  logic     ARESET,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic     [PTR_W-1:0] wr_ptr;
    logic     [PTR_W-1:0] rd_ptr;
    logic     [CNT_W-1:0] count;
    logic                 do_wr;
    logic                 do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head entry falls through
    assign dout = mem[rd_ptr];

    always_ff @(posedge ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge ACLK) disable iff (ARESET)
        wr_en |-> !full);

    a_no_underflow: assert property (@(posedge ACLK) disable iff (ARESET)
        rd_en |-> !empty);

endmodule

//--- hdl/dataframe_gen.sv
`timescale 1ns/1ps
`include "dataframe_macros.svh"

module dataframe_gen (
    input  logic                   ACLK,
    input  logic                   ARESET,

    input  logic                   desc_empty,
    input  frame_pkg::frame_desc_t desc_dout,
    output logic                   desc_rd_en,

    input  logic                   sample_empty,
    input  axis_pkg::beat_t        sample_dout,
    output logic                   sample_rd_en,

    input  logic                   m_axis_tready,
    output logic                   m_axis_tvalid,
    output axis_pkg::beat_t        m_axis_tdata,
    output axis_pkg::keep_t        m_axis_tkeep,
    output logic                   m_axis_tlast,

    output logic                   frame_error
);

    localparam int HDR_IDX_W = (`HEADER_BEATS > 1) ? $clog2(`HEADER_BEATS) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_HEADER,
        S_SAMPLES,
        S_FOOTER
    } state_t;

    state_t                                      state;
    frame_pkg::frame_desc_t                      desc_q;
    frame_pkg::frame_len_t                       frame_len;
    frame_pkg::frame_len_t                       beat_cnt;
    logic [HDR_IDX_W-1:0]                        hdr_idx;
    logic [`HEADER_LINE-1:0][`DATAFRAME_WIDTH-1:0] hdr_words;
    logic [`HEADER_BEATS-1:0][`TDATA_WIDTH-1:0]  header_beats;
    axis_pkg::beat_t                             footer_beat;

    logic                                        load_ok;
    logic                                        samples_done;
    logic                                        load_hdr;
    logic                                        load_smp;
    logic                                        load_ftr;
    logic                                        beat_xfer;

    axis_pkg::beat_t                             next_data;
    axis_pkg::keep_t                             next_keep;
    axis_pkg::beat_t                             tdata_q;
    axis_pkg::keep_t                             tkeep_q;
    logic                                        tvalid_q;
    logic                                        tlast_q;
    logic                                        error_q;

    // ==============================
    // Beat sources
    // ==============================

    assign frame_len = desc_q.header.word0.frame_len;
    assign hdr_words = desc_q.header;
    assign hdr_idx   = beat_cnt[HDR_IDX_W-1:0];

    // Word 0 is the top word of the header; pairs go out little endian
    for (genvar i = 0; i < `HEADER_BEATS; i++) begin : g_hdr_beat
        assign header_beats[i] = {hdr_words[`HEADER_LINE-2-2*i], hdr_words[`HEADER_LINE-1-2*i]};
    end

    assign footer_beat = {{(`TDATA_WIDTH-`DATAFRAME_WIDTH){1'b1}}, desc_q.footer[0]};

    // ==============================
    // Read and load control
    // ==============================

    // Output register is free when empty or draining this cycle
    assign load_ok      = !tvalid_q || m_axis_tready;
    assign beat_xfer    = tvalid_q && m_axis_tready;
    assign samples_done = (beat_cnt == frame_len);

    assign desc_rd_en   = (state == S_IDLE) && !desc_empty;
    assign load_hdr     = (state == S_HEADER) && load_ok;
    assign load_smp     = (state == S_SAMPLES) && load_ok && !samples_done && !sample_empty;
    assign load_ftr     = (state == S_SAMPLES) && load_ok && samples_done;
    assign sample_rd_en = load_smp;

    always_comb begin
        next_data = sample_dout;
        next_keep = axis_pkg::KEEP_FULL;
        if (load_hdr) begin
            next_data = header_beats[hdr_idx];
        end else if (load_ftr) begin
            next_data = footer_beat;
            next_keep = axis_pkg::KEEP_LOW_HALF;
        end
    end

    always_ff @(posedge ACLK) begin
        if (desc_rd_en) begin
            desc_q <= desc_dout;
        end
        if (load_hdr || load_smp || load_ftr) begin
            tdata_q <= next_data;
            tkeep_q <= next_keep;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
            tvalid_q <= 1'b0;
            tlast_q  <= 1'b0;
            error_q  <= 1'b0;
        end else begin
            if (beat_xfer) begin
                tvalid_q <= 1'b0;
            end
            if (load_hdr || load_smp || load_ftr) begin
                tvalid_q <= 1'b1;
                tlast_q  <= load_ftr;
            end

            case (state)
                S_IDLE: begin
                    if (desc_rd_en) begin
                        state    <= S_HEADER;
                        beat_cnt <= '0;
                    end
                end
                S_HEADER: begin
                    if (load_hdr) begin
                        if (beat_cnt == frame_pkg::frame_len_t'(`HEADER_BEATS - 1)) begin
                            state    <= S_SAMPLES;
                            beat_cnt <= '0;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                S_SAMPLES: begin
                    if (load_smp) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (load_ftr) begin
                        state <= S_FOOTER;
                    end
                end
                default: begin
                    // Footer is loaded; frame ends with its transfer
                    if (beat_xfer) begin
                        state <= S_IDLE;
                    end
                end
            endcase

            if (desc_rd_en && sample_empty) begin
                error_q <= 1'b1;
            end
        end
    end

    assign m_axis_tvalid = tvalid_q;
    assign m_axis_tdata  = tdata_q;
    assign m_axis_tkeep  = tkeep_q;
    assign m_axis_tlast  = tlast_q;
    assign frame_error   = error_q;

    // ==============================
    // Stream checks
    // ==============================

    a_valid_held: assert property (@(posedge ACLK) disable iff (ARESET)
        (tvalid_q && !m_axis_tready) |=> tvalid_q);

    a_data_held: assert property (@(posedge ACLK) disable iff (ARESET)
        (tvalid_q && !m_axis_tready) |=> ($stable(tdata_q) && $stable(tlast_q)));

    a_last_keep: assert property (@(posedge ACLK) disable iff (ARESET)
        (tvalid_q && tlast_q) |-> (tkeep_q == axis_pkg::KEEP_LOW_HALF));

endmodule

//--- hdl/dataframe_top.sv
`timescale 1ns/1ps
`include "dataframe_macros.svh"

module dataframe_top (
    input  logic                   ACLK,
    input  logic                   ARESET,

    input  logic                   desc_wr_en,
    input  frame_pkg::frame_desc_t desc_din,
    output logic                   desc_full,

    input  logic                   sample_wr_en,
    input  axis_pkg::beat_t        sample_din,
    output logic                   sample_full,

    output logic                   m_axis_tvalid,
    input  logic                   m_axis_tready,
    output axis_pkg::beat_t        m_axis_tdata,
    output axis_pkg::keep_t        m_axis_tkeep,
    output logic                   m_axis_tlast,

    output logic                   frame_error
);

    logic                   desc_empty;
    logic                   desc_rd_en;
    frame_pkg::frame_desc_t desc_dout;

    logic                   sample_empty;
    logic                   sample_rd_en;
    axis_pkg::beat_t        sample_dout;

    sync_fifo #(
        .payload_t (frame_pkg::frame_desc_t),
        .DEPTH     (`DESC_FIFO_DEPTH)
    ) i_desc_fifo (
        .ACLK   (ACLK),
        .ARESET (ARESET),
        .wr_en  (desc_wr_en),
        .din    (desc_din),
        .full   (desc_full),
        .rd_en  (desc_rd_en),
        .dout   (desc_dout),
        .empty  (desc_empty)
    );

    sync_fifo #(
        .payload_t (axis_pkg::beat_t),
        .DEPTH     (`SAMPLE_FIFO_DEPTH)
    ) i_sample_fifo (
        .ACLK   (ACLK),
        .ARESET (ARESET),
        .wr_en  (sample_wr_en),
        .din    (sample_din),
        .full   (sample_full),
        .rd_en  (sample_rd_en),
        .dout   (sample_dout),
        .empty  (sample_empty)
    );

    dataframe_gen i_gen (
        .ACLK          (ACLK),
        .ARESET        (ARESET),
        .desc_empty    (desc_empty),
        .desc_dout     (desc_dout),
        .desc_rd_en    (desc_rd_en),
        .sample_empty  (sample_empty),
        .sample_dout   (sample_dout),
        .sample_rd_en  (sample_rd_en),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .frame_error   (frame_error)
    );

endmodule

//--- test/tb_dataframe.sv
`timescale 1ns/1ps

module tb_dataframe;

    localparam int N_ROWS     = 7;
    localparam int LATE_DELAY = 12;

    typedef struct packed {
        logic [11:0] len;
        logic [7:0]  ch;
        logic [7:0]  duty;
        logic        late;
    } row_t;

    // frame_len, ch_id, tready duty in percent, samples written late
    localparam row_t ROWS [N_ROWS] = '{
        '{12'd1, 8'h10, 8'd100, 1'b0},
        '{12'd2, 8'h11, 8'd100, 1'b0},
        '{12'd9, 8'h12, 8'd100, 1'b0},
        '{12'd2, 8'h13, 8'd50,  1'b0},
        '{12'd9, 8'h14, 8'd30,  1'b0},
        '{12'd1, 8'h15, 8'd70,  1'b0},
        '{12'd9, 8'h16, 8'd60,  1'b1}
    };

    typedef struct packed {
        logic        last;
        logic [7:0]  keep;
        logic [63:0] data;
    } exp_beat_t;

    logic         ACLK;
    logic         ARESET;
    logic         desc_wr_en;
    logic [159:0] desc_din;
    logic         desc_full;
    logic         sample_wr_en;
    logic [63:0]  sample_din;
    logic         sample_full;
    logic         m_axis_tvalid;
    logic         m_axis_tready;
    logic [63:0]  m_axis_tdata;
    logic [7:0]   m_axis_tkeep;
    logic         m_axis_tlast;
    logic         frame_error;

    exp_beat_t    exp_q [$];
    exp_beat_t    exp_beat;
    int           seed = 32'hde13;
    int           duty = 100;
    logic         stalled;
    logic [63:0]  held_data;
    logic [7:0]   held_keep;
    logic         held_last;

    dataframe_top i_dut (
        .ACLK          (ACLK),
        .ARESET        (ARESET),
        .desc_wr_en    (desc_wr_en),
        .desc_din      (desc_din),
        .desc_full     (desc_full),
        .sample_wr_en  (sample_wr_en),
        .sample_din    (sample_din),
        .sample_full   (sample_full),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .frame_error   (frame_error)
    );

    initial begin
        ACLK = 1'b0;
        forever #50 ACLK = ~ACLK;
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic abort_run(input string reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run("value mismatch on the stream");
        end
    endtask

    function automatic logic draw_ready();
        int r;
        r = $random(seed);
        return ((r & 32'h7fff_ffff) % 100) < duty;
    endfunction

    task automatic write_sample(input logic [63:0] d);
        while (sample_full) @(negedge ACLK);
        sample_din   = d;
        sample_wr_en = 1'b1;
        @(negedge ACLK);
        sample_wr_en = 1'b0;
    endtask

    task automatic write_desc(input logic [159:0] d);
        while (desc_full) @(negedge ACLK);
        desc_din   = d;
        desc_wr_en = 1'b1;
        @(negedge ACLK);
        desc_wr_en = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge ACLK);
    endtask

    task automatic run_row(input row_t row);
        logic [31:0] w [4];
        logic [31:0] footer;
        logic [63:0] smp [$];
        int          r;
        r      = $random(seed);
        w[0]   = {r[7:0], row.ch, row.len, r[11:8]};
        w[1]   = $random(seed);
        w[2]   = $random(seed);
        w[3]   = $random(seed);
        footer = $random(seed);
        for (int i = 0; i < int'(row.len); i++) begin
            smp.push_back({$random(seed), $random(seed)});
        end

        // Header pairs with the first word low, then samples, then the padded footer
        exp_q.push_back('{1'b0, 8'hFF, {w[1], w[0]}});
        exp_q.push_back('{1'b0, 8'hFF, {w[3], w[2]}});
        foreach (smp[i]) begin
            exp_q.push_back('{1'b0, 8'hFF, smp[i]});
        end
        exp_q.push_back('{1'b1, 8'h0F, {32'hFFFF_FFFF, footer}});

        duty = int'(row.duty);
        if (row.late) begin
            write_desc({w[0], w[1], w[2], w[3], footer});
            repeat (LATE_DELAY) @(negedge ACLK);
            check("frame_error after empty start", 64'(frame_error), 64'd1);
            foreach (smp[i]) write_sample(smp[i]);
        end else begin
            foreach (smp[i]) write_sample(smp[i]);
            write_desc({w[0], w[1], w[2], w[3], footer});
        end
    endtask

    // ==============================
    // Stream monitor
    // ==============================

    initial begin
        m_axis_tready = 1'b0;
        forever begin
            @(negedge ACLK);
            m_axis_tready = draw_ready();
        end
    end

    always @(posedge ACLK) begin
        if (ARESET) begin
            stalled <= 1'b0;
        end else begin
            if (stalled) begin
                check("tvalid while stalled", 64'(m_axis_tvalid), 64'd1);
                check("tdata while stalled", m_axis_tdata, held_data);
                check("tkeep while stalled", 64'(m_axis_tkeep), 64'(held_keep));
                check("tlast while stalled", 64'(m_axis_tlast), 64'(held_last));
            end
            if (m_axis_tvalid && m_axis_tready) begin
                if (exp_q.size() == 0) begin
                    abort_run("a beat was transferred while none was expected");
                end else begin
                    exp_beat = exp_q.pop_front();
                    check("tdata", m_axis_tdata, exp_beat.data);
                    check("tkeep", 64'(m_axis_tkeep), 64'(exp_beat.keep));
                    check("tlast", 64'(m_axis_tlast), 64'(exp_beat.last));
                end
            end
            stalled   <= m_axis_tvalid && !m_axis_tready;
            held_data <= m_axis_tdata;
            held_keep <= m_axis_tkeep;
            held_last <= m_axis_tlast;
        end
    end

    // Watchdog sized from the frame lengths in the table
    initial begin
        int limit;
        limit = 0;
        for (int i = 0; i < N_ROWS; i++) begin
            limit += (int'(ROWS[i].len) + 3) * 20;
        end
        repeat (limit) @(posedge ACLK);
        $display("Stream stalled: frames not finished after %0d cycles", limit);
        abort_run("watchdog expired");
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        ARESET       = 1'b1;
        desc_wr_en   = 1'b0;
        desc_din     = '0;
        sample_wr_en = 1'b0;
        sample_din   = '0;
        repeat (3) @(posedge ACLK);
        @(negedge ACLK);
        ARESET = 1'b0;
        check("tvalid after reset", 64'(m_axis_tvalid), 64'd0);
        check("frame_error after reset", 64'(frame_error), 64'd0);
        check("desc_full after reset", 64'(desc_full), 64'd0);
        check("sample_full after reset", 64'(sample_full), 64'd0);

        for (int i = 0; i < N_ROWS; i++) begin
            if (ROWS[i].late) begin
                drain();
                check("frame_error before empty start", 64'(frame_error), 64'd0);
            end
            run_row(ROWS[i]);
        end

        drain();
        repeat (5) @(negedge ACLK);
        check("frame_error at end", 64'(frame_error), 64'd1);
        check("tvalid at end", 64'(m_axis_tvalid), 64'd0);
        check("desc_full at end", 64'(desc_full), 64'd0);
        check("sample_full at end", 64'(sample_full), 64'd0);
        if (exp_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run("expected beats were never transferred");
        end
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/frame_pkg.sv
hdl/axis_pkg.sv
hdl/sync_fifo.sv
hdl/dataframe_gen.sv
hdl/dataframe_top.sv
test/tb_dataframe.sv

//--- Makefile
SRCS := hdl/dataframe_macros.svh hdl/frame_pkg.sv hdl/axis_pkg.sv hdl/sync_fifo.sv \
        hdl/dataframe_gen.sv hdl/dataframe_top.sv test/tb_dataframe.sv

.PHONY: all run clean

all: obj_dir/Vtb_dataframe

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_dataframe: filelist.f $(SRCS)
	verilator --binary --timing --assert -f filelist.f --top-module tb_dataframe \
		-o Vtb_dataframe

# Exit status of the simulator is the test result
run: obj_dir/Vtb_dataframe
	./obj_dir/Vtb_dataframe

clean:
	rm -rf obj_dir
